// File: source/l2_pkg.sv
package l2_pkg;

  // Port and bank organisation
  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 256;

  // Word format
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = 4;
  localparam int unsigned BYTE_WIDTH = DATA_WIDTH / BE_WIDTH;

  // Address window of the L2 memory
  localparam int unsigned            ADDR_WIDTH   = 32;
  localparam logic [ADDR_WIDTH-1:0]  L2_BASE_ADDR = 32'h8000_0000;
  localparam int unsigned            L2_WORDS     = NUM_BANKS * BANK_WORDS;

  // Derived index widths
  localparam int unsigned BYTE_OFFSET_WIDTH = $clog2(BE_WIDTH);
  localparam int unsigned BANK_SEL_WIDTH    = $clog2(NUM_BANKS);
  localparam int unsigned PORT_SEL_WIDTH    = $clog2(NUM_PORTS);
  localparam int unsigned ROW_WIDTH         = $clog2(BANK_WORDS);

  // Row, write enable, byte enables and write data toward one bank
  localparam int unsigned REQ_PAYLOAD_WIDTH = ROW_WIDTH + 1 + BE_WIDTH + DATA_WIDTH;

endpackage

// File: source/l2_addr_map.sv
`timescale 1ns/1ps

module l2_addr_map
  import l2_pkg::*;
(
  input  logic [ADDR_WIDTH-1:0]     addr_i,
  output logic [BANK_SEL_WIDTH-1:0] bank_o,
  output logic [ROW_WIDTH-1:0]      row_o,
  output logic                      in_range_o
);

  // Word index relative to the start of the L2 window
  logic [ADDR_WIDTH-1:0] word_addr;

  assign word_addr = (addr_i - L2_BASE_ADDR) >> BYTE_OFFSET_WIDTH;

  // Consecutive words land in consecutive banks
  assign bank_o = word_addr[BANK_SEL_WIDTH-1:0];

  // Remaining bits address the row inside the selected bank
  assign row_o = word_addr[BANK_SEL_WIDTH +: ROW_WIDTH];

  // Below the base the subtraction wraps, so both bounds are checked
  assign in_range_o = (addr_i >= L2_BASE_ADDR) &&
                      (word_addr < ADDR_WIDTH'(L2_WORDS));

endmodule

// File: source/l2_bank_arbiter.sv
`timescale 1ns/1ps

module l2_bank_arbiter
  import l2_pkg::*;
(
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic [NUM_PORTS-1:0]                      req_i,
  input  logic [NUM_PORTS-1:0]                      in_range_i,
  input  logic [NUM_PORTS-1:0][BANK_SEL_WIDTH-1:0]  bank_i,
  output logic [NUM_PORTS-1:0]                      port_gnt_o,
  output logic [NUM_BANKS-1:0]                      bank_req_o,
  output logic [NUM_BANKS-1:0][NUM_PORTS-1:0]       bank_sel_o,
  output logic [NUM_PORTS-1:0]                      resp_valid_o,
  output logic [NUM_PORTS-1:0]                      resp_err_o,
  output logic [NUM_PORTS-1:0][NUM_BANKS-1:0]       resp_bank_o
);

  logic [NUM_BANKS-1:0][NUM_PORTS-1:0]      bank_hit;
  logic [NUM_BANKS-1:0][PORT_SEL_WIDTH-1:0] rr_ptr_q;
  logic [NUM_BANKS-1:0][PORT_SEL_WIDTH-1:0] rr_ptr_d;
  logic [NUM_PORTS-1:0][NUM_BANKS-1:0]      port_bank;

  // In-range requests that target each bank, none while in reset
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_hit_bank
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_hit_port
      assign bank_hit[b][p] = !reset_i && req_i[p] && in_range_i[p] &&
                              (bank_i[p] == BANK_SEL_WIDTH'(b));
    end
  end

  // Round-robin search starting at the pointer of each bank
  always_comb begin
    int unsigned p;
    bank_req_o = '0;
    bank_sel_o = '0;
    rr_ptr_d   = rr_ptr_q;
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      for (int unsigned k = 0; k < NUM_PORTS; k++) begin
        p = (32'(rr_ptr_q[b]) + k) % NUM_PORTS;
        if (!bank_req_o[b] && bank_hit[b][p]) begin
          bank_req_o[b]    = 1'b1;
          bank_sel_o[b][p] = 1'b1;
          // Next search starts just after the winner
          if (p == NUM_PORTS - 1) begin
            rr_ptr_d[b] = '0;
          end else begin
            rr_ptr_d[b] = PORT_SEL_WIDTH'(p + 1);
          end
        end
      end
    end
  end

  // Port view of the bank grants
  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      // Out-of-range requests never wait for a bank
      port_gnt_o[p] = !reset_i && req_i[p] && !in_range_i[p];
      for (int unsigned b = 0; b < NUM_BANKS; b++) begin
        port_bank[p][b] = bank_sel_o[b][p];
        port_gnt_o[p]   = port_gnt_o[p] | bank_sel_o[b][p];
      end
    end
  end

  // Response routing registered one cycle behind the grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q     <= '0;
      resp_valid_o <= '0;
      resp_err_o   <= '0;
      resp_bank_o  <= '0;
    end else begin
      rr_ptr_q     <= rr_ptr_d;
      resp_valid_o <= port_gnt_o;
      resp_err_o   <= req_i & ~in_range_i;
      resp_bank_o  <= port_bank;
    end
  end

endmodule

// File: source/l2_onehot_mux.sv
`timescale 1ns/1ps

module l2_onehot_mux
  import l2_pkg::*;
#(
  parameter type         payload_t = logic [DATA_WIDTH-1:0],
  parameter int unsigned NUM_SRC   = NUM_PORTS
) (
  input  logic     [NUM_SRC-1:0] sel_i,
  input  payload_t [NUM_SRC-1:0] data_i,
  output payload_t               data_o
);

  localparam int unsigned PAYLOAD_BITS = $bits(payload_t);

  // AND-OR selection, an empty select yields zero
  always_comb begin
    data_o = '0;
    for (int unsigned i = 0; i < NUM_SRC; i++) begin
      data_o = payload_t'(data_o | (data_i[i] & {PAYLOAD_BITS{sel_i[i]}}));
    end
  end

endmodule

// File: source/l2_sram_bank.sv
`timescale 1ns/1ps

module l2_sram_bank
  import l2_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [BE_WIDTH-1:0]   be_i,
  input  logic [ROW_WIDTH-1:0]  row_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic [DATA_WIDTH-1:0] mem_q [BANK_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only enabled bytes are written
        for (int unsigned i = 0; i < BE_WIDTH; i++) begin
          if (be_i[i]) begin
            mem_q[row_i][i*BYTE_WIDTH +: BYTE_WIDTH] <= wdata_i[i*BYTE_WIDTH +: BYTE_WIDTH];
          end
        end
      end else begin
        // Read word appears on the output in the next cycle
        rdata_o <= mem_q[row_i];
      end
    end
  end

endmodule

// File: source/l2_subsystem.sv
`timescale 1ns/1ps

module l2_subsystem
  import l2_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [NUM_PORTS-1:0]                  req_i,
  input  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0]  addr_i,
  input  logic [NUM_PORTS-1:0]                  we_i,
  input  logic [NUM_PORTS-1:0][BE_WIDTH-1:0]    be_i,
  input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  wdata_i,
  output logic [NUM_PORTS-1:0]                  gnt_o,
  output logic [NUM_PORTS-1:0]                  rvalid_o,
  output logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  rdata_o,
  output logic [NUM_PORTS-1:0]                  err_o
);

  typedef logic [REQ_PAYLOAD_WIDTH-1:0] req_payload_t;
  typedef logic [DATA_WIDTH-1:0]        data_t;

  // Port side
  logic [NUM_PORTS-1:0][BANK_SEL_WIDTH-1:0] port_bank;
  logic [NUM_PORTS-1:0][ROW_WIDTH-1:0]      port_row;
  logic [NUM_PORTS-1:0]                     port_in_range;
  req_payload_t [NUM_PORTS-1:0]             port_payload;
  logic [NUM_PORTS-1:0][NUM_BANKS-1:0]      resp_bank;

  // Bank side
  logic [NUM_BANKS-1:0]                     bank_req;
  logic [NUM_BANKS-1:0][NUM_PORTS-1:0]      bank_sel;
  req_payload_t [NUM_BANKS-1:0]             bank_payload;
  logic [NUM_BANKS-1:0][ROW_WIDTH-1:0]      bank_row;
  logic [NUM_BANKS-1:0]                     bank_we;
  logic [NUM_BANKS-1:0][BE_WIDTH-1:0]       bank_be;
  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]     bank_wdata;
  data_t [NUM_BANKS-1:0]                    bank_rdata;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    l2_addr_map i_addr_map (
      .addr_i     ( addr_i[p]        ),
      .bank_o     ( port_bank[p]     ),
      .row_o      ( port_row[p]      ),
      .in_range_o ( port_in_range[p] )
    );

    assign port_payload[p] = {port_row[p], we_i[p], be_i[p], wdata_i[p]};

    // Read data from the bank that served this port one cycle ago
    l2_onehot_mux #(
      .payload_t ( data_t    ),
      .NUM_SRC   ( NUM_BANKS )
    ) i_rdata_mux (
      .sel_i  ( resp_bank[p] ),
      .data_i ( bank_rdata   ),
      .data_o ( rdata_o[p]   )
    );
  end

  l2_bank_arbiter i_bank_arbiter (
    .clk_i        ( clk_i         ),
    .reset_i      ( reset_i       ),
    .req_i        ( req_i         ),
    .in_range_i   ( port_in_range ),
    .bank_i       ( port_bank     ),
    .port_gnt_o   ( gnt_o         ),
    .bank_req_o   ( bank_req      ),
    .bank_sel_o   ( bank_sel      ),
    .resp_valid_o ( rvalid_o      ),
    .resp_err_o   ( err_o         ),
    .resp_bank_o  ( resp_bank     )
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    // Request of the winning port toward this bank
    l2_onehot_mux #(
      .payload_t ( req_payload_t ),
      .NUM_SRC   ( NUM_PORTS     )
    ) i_req_mux (
      .sel_i  ( bank_sel[b]     ),
      .data_i ( port_payload    ),
      .data_o ( bank_payload[b] )
    );

    assign {bank_row[b], bank_we[b], bank_be[b], bank_wdata[b]} = bank_payload[b];

    l2_sram_bank i_sram_bank (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[b]   ),
      .we_i    ( bank_we[b]    ),
      .be_i    ( bank_be[b]    ),
      .row_i   ( bank_row[b]   ),
      .wdata_i ( bank_wdata[b] ),
      .rdata_o ( bank_rdata[b] )
    );
  end

endmodule

// File: tests/l2_bank_arbiter_chk.sv
`timescale 1ns/1ps

module l2_bank_arbiter_chk
  import l2_pkg::*;
(
  input logic                                clk_i,
  input logic                                reset_i,
  input logic [NUM_PORTS-1:0]                req_i,
  input logic [NUM_PORTS-1:0]                port_gnt_i,
  input logic [NUM_BANKS-1:0][NUM_PORTS-1:0] bank_sel_i,
  input logic [NUM_PORTS-1:0]                resp_valid_i
);

  // A bank serves at most one port per cycle
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    a_sel_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(bank_sel_i[b]))
      else $error("bank_sel_o of bank %0d selects more than one port", b);
  end

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    (port_gnt_i & ~req_i) == '0)
    else $error("port_gnt_o set for a port without a request");

  // Response valid is the grant delayed by one cycle
  a_resp_follows_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> resp_valid_i == $past(port_gnt_i))
    else $error("resp_valid_o does not match port_gnt_o of the previous cycle");

  a_no_gnt_in_reset: assert property (@(posedge clk_i)
    reset_i |-> port_gnt_i == '0)
    else $error("port_gnt_o set during reset");

endmodule

bind l2_bank_arbiter l2_bank_arbiter_chk i_bank_arbiter_chk (
  .clk_i        ( clk_i        ),
  .reset_i      ( reset_i      ),
  .req_i        ( req_i        ),
  .port_gnt_i   ( port_gnt_o   ),
  .bank_sel_i   ( bank_sel_o   ),
  .resp_valid_i ( resp_valid_o )
);

// File: tests/l2_subsystem_tb.sv
`timescale 1ns/1ps

module l2_subsystem_tb
  import l2_pkg::*;
();

  localparam int unsigned RANDOM_CYCLES = 3000;
  localparam int unsigned IDLE_LIMIT    = 50;

  logic                                 clk;
  logic                                 reset;
  logic [NUM_PORTS-1:0]                 req;
  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] addr;
  logic [NUM_PORTS-1:0]                 we;
  logic [NUM_PORTS-1:0][BE_WIDTH-1:0]   be;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] wdata;
  logic [NUM_PORTS-1:0]                 gnt;
  logic [NUM_PORTS-1:0]                 rvalid;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] rdata;
  logic [NUM_PORTS-1:0]                 err;

  integer seed;

  // Reference memory for the whole L2 window and its own round-robin pointers
  logic [DATA_WIDTH-1:0] model_mem [L2_WORDS];
  int unsigned           rr_ptr    [NUM_BANKS];

  // Request held by each port until it is granted
  logic                  pend       [NUM_PORTS];
  logic [ADDR_WIDTH-1:0] pend_addr  [NUM_PORTS];
  logic                  pend_we    [NUM_PORTS];
  logic [BE_WIDTH-1:0]   pend_be    [NUM_PORTS];
  logic [DATA_WIDTH-1:0] pend_wdata [NUM_PORTS];
  int unsigned           pend_wait  [NUM_PORTS];

  // Response expected one cycle after a grant
  logic                  exp_valid [NUM_PORTS];
  logic                  exp_err   [NUM_PORTS];
  logic                  exp_read  [NUM_PORTS];
  logic [DATA_WIDTH-1:0] exp_rdata [NUM_PORTS];

  l2_subsystem i_l2_subsystem (
    .clk_i    ( clk    ),
    .reset_i  ( reset  ),
    .req_i    ( req    ),
    .addr_i   ( addr   ),
    .we_i     ( we     ),
    .be_i     ( be     ),
    .wdata_i  ( wdata  ),
    .gnt_o    ( gnt    ),
    .rvalid_o ( rvalid ),
    .rdata_o  ( rdata  ),
    .err_o    ( err    )
  );

  always #4 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, expected);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  function automatic logic addr_in_range(input logic [ADDR_WIDTH-1:0] a);
    return (a >= L2_BASE_ADDR) && ((a - L2_BASE_ADDR) < ADDR_WIDTH'(L2_WORDS * BE_WIDTH));
  endfunction

  // Word index inside the window for an in-range address
  function automatic int unsigned addr_word(input logic [ADDR_WIDTH-1:0] a);
    return (a - L2_BASE_ADDR) / BE_WIDTH;
  endfunction

  task automatic issue(input int unsigned p, input logic [ADDR_WIDTH-1:0] a, input logic w,
                       input logic [BE_WIDTH-1:0] b, input logic [DATA_WIDTH-1:0] d);
    pend[p]       = 1'b1;
    pend_addr[p]  = a;
    pend_we[p]    = w;
    pend_be[p]    = b;
    pend_wdata[p] = d;
    pend_wait[p]  = 0;
  endtask

  task automatic rand_request(input int unsigned p);
    logic [ADDR_WIDTH-1:0] a;
    int unsigned           w;
    w = $unsigned($random(seed)) % L2_WORDS;
    a = L2_BASE_ADDR + ADDR_WIDTH'(w * BE_WIDTH);
    // About one request in eight misses the window
    if (($random(seed) & 7) == 0) begin
      if (($random(seed) & 1) == 1) begin
        a = L2_BASE_ADDR + ADDR_WIDTH'((L2_WORDS + w) * BE_WIDTH);
      end else begin
        a = L2_BASE_ADDR - ADDR_WIDTH'((w + 1) * BE_WIDTH);
      end
    end
    issue(p, a, 1'($random(seed)), BE_WIDTH'($random(seed)), $random(seed));
  endtask

  task automatic run_cycle();
    logic [NUM_PORTS-1:0] pred;
    logic                 won;
    int unsigned          p;
    int unsigned          winner;
    int unsigned          w;
    @(negedge clk);
    // Responses to the grants of the previous cycle
    for (int unsigned q = 0; q < NUM_PORTS; q++) begin
      check($sformatf("rvalid_o[%0d]", q), 64'(rvalid[q]), 64'(exp_valid[q]));
      check($sformatf("err_o[%0d]", q), 64'(err[q]), 64'(exp_err[q]));
      if (exp_read[q]) begin
        check($sformatf("rdata_o[%0d]", q), 64'(rdata[q]), 64'(exp_rdata[q]));
      end
    end
    for (int unsigned q = 0; q < NUM_PORTS; q++) begin
      req[q]   = pend[q];
      addr[q]  = pend_addr[q];
      we[q]    = pend_we[q];
      be[q]    = pend_be[q];
      wdata[q] = pend_wdata[q];
    end
    #1;
    // Out-of-range requests are granted at once
    pred = '0;
    for (int unsigned q = 0; q < NUM_PORTS; q++) begin
      if (pend[q] && !addr_in_range(pend_addr[q])) begin
        pred[q] = 1'b1;
      end
    end
    // Round robin per bank starting at the pointer
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      won    = 1'b0;
      winner = 0;
      for (int unsigned k = 0; k < NUM_PORTS; k++) begin
        p = (rr_ptr[b] + k) % NUM_PORTS;
        if (!won && pend[p] && addr_in_range(pend_addr[p]) &&
            (addr_word(pend_addr[p]) % NUM_BANKS == b)) begin
          won     = 1'b1;
          winner  = p;
          pred[p] = 1'b1;
        end
      end
      if (won) begin
        rr_ptr[b] = (winner + 1) % NUM_PORTS;
      end
    end
    check("gnt_o", 64'(gnt), 64'(pred));
    for (int unsigned q = 0; q < NUM_PORTS; q++) begin
      exp_valid[q] = pred[q];
      exp_err[q]   = pred[q] && !addr_in_range(pend_addr[q]);
      exp_read[q]  = pred[q] && addr_in_range(pend_addr[q]) && !pend_we[q];
      if (exp_read[q]) begin
        exp_rdata[q] = model_mem[addr_word(pend_addr[q])];
      end
      if (pred[q] && addr_in_range(pend_addr[q]) && pend_we[q]) begin
        w = addr_word(pend_addr[q]);
        for (int unsigned i = 0; i < BE_WIDTH; i++) begin
          if (pend_be[q][i]) begin
            model_mem[w][i*BYTE_WIDTH +: BYTE_WIDTH] = pend_wdata[q][i*BYTE_WIDTH +: BYTE_WIDTH];
          end
        end
      end
      if (pred[q]) begin
        pend[q] = 1'b0;
      end else if (pend[q]) begin
        pend_wait[q]++;
        if (pend_wait[q] == NUM_PORTS) begin
          fail_run($sformatf("Port %0d held a request too long without a grant", q));
        end
      end
    end
  endtask

  // Runs cycles until every held request has been granted
  task automatic wait_idle();
    int unsigned cycles;
    logic        busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int unsigned q = 0; q < NUM_PORTS; q++) begin
        if (pend[q]) begin
          busy = 1'b1;
        end
      end
      if (busy && cycles == IDLE_LIMIT) begin
        fail_run("Timeout while waiting for the pending requests to be granted");
      end else if (busy) begin
        run_cycle();
        cycles++;
      end
    end
  endtask

  initial begin
    seed  = 67908;
    clk   = 1'b0;
    reset = 1'b1;
    req   = '0;
    addr  = '0;
    we    = '0;
    be    = '0;
    wdata = '0;
    for (int unsigned q = 0; q < NUM_PORTS; q++) begin
      pend[q]      = 1'b0;
      pend_addr[q] = '0;
      pend_we[q]   = 1'b0;
      pend_be[q]   = '0;
      pend_wdata[q] = '0;
      pend_wait[q] = 0;
      exp_valid[q] = 1'b0;
      exp_err[q]   = 1'b0;
      exp_read[q]  = 1'b0;
      exp_rdata[q] = '0;
    end
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      rr_ptr[b] = 0;
    end

    // Requests held during reset, in range on most ports and out of range on the last
    for (int unsigned q = 0; q < NUM_PORTS; q++) begin
      req[q]  = 1'b1;
      addr[q] = L2_BASE_ADDR + ADDR_WIDTH'(q * BE_WIDTH);
      we[q]   = 1'b1;
      be[q]   = '1;
    end
    addr[NUM_PORTS-1] = L2_BASE_ADDR - ADDR_WIDTH'(BE_WIDTH);

    // Nothing is granted or answered while reset is high
    for (int unsigned c = 0; c < 4; c++) begin
      @(negedge clk);
      check("gnt_o", 64'(gnt), 64'(0));
      check("rvalid_o", 64'(rvalid), 64'(0));
      check("err_o", 64'(err), 64'(0));
    end
    req   = '0;
    reset = 1'b0;

    // Nothing granted or answered while idle
    repeat (3) run_cycle();

    // Port 0 fills every word so the model is fully defined
    for (int unsigned w = 0; w < L2_WORDS; w++) begin
      issue(0, L2_BASE_ADDR + ADDR_WIDTH'(w * BE_WIDTH), 1'b1, '1, $random(seed));
      wait_idle();
    end

    for (int unsigned c = 0; c < RANDOM_CYCLES; c++) begin
      for (int unsigned q = 0; q < NUM_PORTS; q++) begin
        if (!pend[q] && ($random(seed) & 3) != 0) begin
          rand_request(q);
        end
      end
      run_cycle();
    end
    wait_idle();

    // Full read back shows that out-of-range writes left no trace
    for (int unsigned w = 0; w < L2_WORDS; w++) begin
      issue(0, L2_BASE_ADDR + ADDR_WIDTH'(w * BE_WIDTH), 1'b0, '1, '0);
      wait_idle();
    end
    run_cycle();

    $display("All checks passed");
    $finish;
  end

endmodule

// File: project.f
source/l2_pkg.sv
source/l2_addr_map.sv
source/l2_bank_arbiter.sv
source/l2_onehot_mux.sv
source/l2_sram_bank.sv
source/l2_subsystem.sv
tests/l2_bank_arbiter_chk.sv
tests/l2_subsystem_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= l2_subsystem_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All checks passed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
